//--- source/ldst_params.svh
`ifndef LDST_PARAMS_SVH
`define LDST_PARAMS_SVH

// System bus data width in bits
`define LDST_AXI_DATA_W 64

// Data width of one cluster port
`define LDST_CL_DATA_W 16

// Number of clusters fed by the read path
`define LDST_NR_CL 8

// Byte address width
`define LDST_ADDR_W 32

// 4 KiB pages
`define LDST_PAGE_BITS 12

// AXI4 burst limit in beats
`define LDST_MAX_BURST 256

// Width of a vector length in elements
`define LDST_VL_W 16

`endif

//--- source/ldst_addr_pkg.sv
`include "ldst_params.svh"

package ldst_addr_pkg;

  // Byte address on the system bus
  typedef logic [`LDST_ADDR_W-1:0] addr_t;

  // Address split at the page boundary
  typedef struct packed {
    logic [`LDST_ADDR_W-`LDST_PAGE_BITS-1:0] page;
    logic [`LDST_PAGE_BITS-1:0]              offset;
  } page_split_t;

  // Flat view for arithmetic, split view for page tests
  typedef union packed {
    addr_t       flat;
    page_split_t split;
  } page_addr_u;

  // AXI len field, beats minus one
  typedef logic [7:0] ar_len_t;

  // Beat count of one burst, wide enough for a full page of beats
  typedef logic [`LDST_PAGE_BITS:0] beat_cnt_t;

  // Vector length in elements
  typedef logic [`LDST_VL_W-1:0] vl_t;

  // Element width code, element size is 1 << vsew bytes
  typedef logic [1:0] vsew_t;

endpackage

//--- source/ldst_beat_pkg.sv
`include "ldst_params.svh"

package ldst_beat_pkg;

  // One beat of the wide system bus
  typedef logic [`LDST_AXI_DATA_W-1:0] axi_data_t;

  // One slice as seen by a cluster port
  typedef logic [`LDST_CL_DATA_W-1:0] cl_data_t;

  // AXI read response code
  typedef logic [1:0] rresp_t;

  // Index of the next cluster to fill
  typedef logic [$clog2(`LDST_NR_CL)-1:0] cl_ptr_t;

endpackage

//--- source/burst_if.sv
`timescale 1ns/1ps

interface burst_if;
  import ldst_addr_pkg::*;

  // Current position of the outstanding load
  addr_t   cur_addr;
  vl_t     rem_vl;
  vsew_t   vsew;

  // Burst computed for that position
  ar_len_t ar_len;
  addr_t   next_addr;
  vl_t     vl_done;
  logic    last_burst;

  modport ctrl (
    output cur_addr, rem_vl, vsew,
    input  ar_len, next_addr, vl_done, last_burst
  );

  modport calc (
    input  cur_addr, rem_vl, vsew,
    output ar_len, next_addr, vl_done, last_burst
  );

endinterface

//--- source/burst_calc.sv
`timescale 1ns/1ps
`include "ldst_params.svh"

module burst_calc (
  burst_if.calc burst
);
  import ldst_addr_pkg::*;

  localparam int unsigned BEAT_BYTES = `LDST_AXI_DATA_W / 8;
  localparam int unsigned BEAT_SHIFT = $clog2(BEAT_BYTES);
  localparam int unsigned MAX_BURST  = `LDST_MAX_BURST;

  page_addr_u start_u;
  page_addr_u last_u;
  page_addr_u end_u;
  page_addr_u cur_u;
  page_addr_u tail_u;
  addr_t      byte_len;
  addr_t      span;
  addr_t      next_addr;
  beat_cnt_t  beats;

  always_comb begin
    byte_len = addr_t'(burst.rem_vl) << burst.vsew;

    // Beat aligned start of this burst
    start_u.flat = burst.cur_addr & ~addr_t'(BEAT_BYTES - 1);

    // Last byte of the beat that holds the final element
    last_u.flat = (burst.cur_addr + byte_len - addr_t'(1)) | addr_t'(BEAT_BYTES - 1);

    // Stop at the end of the start page
    end_u = last_u;
    if (last_u.split.page != start_u.split.page) begin
      end_u.split.page   = start_u.split.page;
      end_u.split.offset = '1;
    end

    span  = end_u.flat - start_u.flat;
    beats = beat_cnt_t'(span >> BEAT_SHIFT) + beat_cnt_t'(1);

    // Long loads inside one page are cut at the AXI burst limit
    if (beats > beat_cnt_t'(MAX_BURST)) begin
      beats      = beat_cnt_t'(MAX_BURST);
      end_u.flat = start_u.flat + addr_t'(MAX_BURST * BEAT_BYTES) - addr_t'(1);
    end
  end

  assign next_addr = end_u.flat + addr_t'(1);

  assign burst.ar_len     = ar_len_t'(beats - beat_cnt_t'(1));
  assign burst.next_addr  = next_addr;
  assign burst.vl_done    = vl_t'((next_addr - burst.cur_addr) >> burst.vsew);
  assign burst.last_burst = burst.rem_vl <= burst.vl_done;

  // Page views of what the AR channel will actually carry
  assign cur_u.flat  = burst.cur_addr;
  assign tail_u.flat = next_addr - addr_t'(1);

  // The final byte of the issued burst sits in the page of its first byte
  a_same_page: assert final (
    $isunknown(burst.cur_addr) || (tail_u.split.page == cur_u.split.page)
  ) else $error("burst crosses a 4 KiB page");

endmodule

//--- source/ar_req_ctrl.sv
`timescale 1ns/1ps

module ar_req_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Vector load request
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  ldst_addr_pkg::addr_t   req_addr_i,
  input  ldst_addr_pkg::vl_t     req_vl_i,
  input  ldst_addr_pkg::vsew_t   req_vsew_i,

  // AR channel towards the system bus
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output ldst_addr_pkg::addr_t   ar_addr_o,
  output ldst_addr_pkg::ar_len_t ar_len_o,
  output logic                   done_o,

  // Burst calculation for the current position
  burst_if.ctrl                  burst
);
  import ldst_addr_pkg::*;

  logic  busy_q;
  addr_t addr_q;
  vl_t   vl_q;
  vsew_t vsew_q;

  logic  req_hs;
  logic  ar_hs;

  assign req_ready_o = ~busy_q;
  assign req_hs      = req_valid_i & req_ready_o;

  // One burst is presented as long as a load is outstanding
  assign ar_valid_o = busy_q;
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = burst.ar_len;
  assign ar_hs      = ar_valid_o & ar_ready_i;

  assign done_o = ar_hs & burst.last_burst;

  assign burst.cur_addr = addr_q;
  assign burst.rem_vl   = vl_q;
  assign burst.vsew     = vsew_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      addr_q <= '0;
      vl_q   <= '0;
      vsew_q <= '0;
    end else if (req_hs) begin
      busy_q <= 1'b1;
      addr_q <= req_addr_i;
      vl_q   <= req_vl_i;
      vsew_q <= req_vsew_i;
    end else if (ar_hs) begin
      if (burst.last_burst) begin
        busy_q <= 1'b0;
      end else begin
        // Later bursts start on a beat boundary
        addr_q <= burst.next_addr;
        vl_q   <= vl_q - burst.vl_done;
      end
    end
  end

  // A stalled AR keeps its address and the length computed downstream
  property p_ar_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o);
  endproperty
  a_ar_stable: assert property (p_ar_stable)
    else $error("AR fields changed while stalled");

  // Requests are taken only while idle, and AR follows one cycle later
  property p_accept_idle;
    @(posedge clk_i) disable iff (!rst_ni)
      req_valid_i && req_ready_o |-> !ar_valid_o ##1 ar_valid_o;
  endproperty
  a_accept_idle: assert property (p_accept_idle)
    else $error("request accepted while a load is outstanding");

endmodule

//--- source/r_beat_distributor.sv
`timescale 1ns/1ps
`include "ldst_params.svh"

module r_beat_distributor (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,

  // R channel from the system bus
  input  logic                                        r_valid_i,
  output logic                                        r_ready_o,
  input  ldst_beat_pkg::axi_data_t                    r_data_i,
  input  ldst_beat_pkg::rresp_t                       r_resp_i,
  input  logic                                        r_last_i,

  // Narrow cluster ports
  input  logic [`LDST_NR_CL-1:0]                      cl_r_ready_i,
  output logic                                        cl_r_valid_o,
  output ldst_beat_pkg::cl_data_t [`LDST_NR_CL-1:0]   cl_r_data_o,
  output ldst_beat_pkg::rresp_t                       cl_r_resp_o,
  output logic                                        cl_r_last_o
);
  import ldst_beat_pkg::*;

  // Clusters filled by one wide beat
  localparam int unsigned SLICES = `LDST_AXI_DATA_W / `LDST_CL_DATA_W;
  localparam int unsigned NR_CL  = `LDST_NR_CL;

  cl_ptr_t                ptr_q;
  cl_data_t [NR_CL-1:0]   slice_q;
  rresp_t                 resp_q;
  logic                   last_q;
  logic                   valid_q;

  logic                   r_hs;
  logic                   group_done;

  // Every cluster must be able to take its slice
  assign r_ready_o = &cl_r_ready_i;
  assign r_hs      = r_valid_i & r_ready_o;

  // Group closes on the beat that fills the top cluster or on last
  assign group_done = r_hs & ((ptr_q == cl_ptr_t'(NR_CL - SLICES)) | r_last_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= group_done;
      if (group_done) begin
        ptr_q <= '0;
      end else if (r_hs) begin
        ptr_q <= cl_ptr_t'(ptr_q + SLICES);
      end
    end
  end

  // Slices of clusters not reached by this group keep older data
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      for (int i = 0; i < SLICES; i++) begin
        slice_q[cl_ptr_t'(ptr_q + i)] <= r_data_i[i*`LDST_CL_DATA_W +: `LDST_CL_DATA_W];
      end
    end
    if (group_done) begin
      resp_q <= r_resp_i;
      last_q <= r_last_i;
    end
  end

  assign cl_r_valid_o = valid_q;
  assign cl_r_data_o  = slice_q;
  assign cl_r_resp_o  = resp_q;
  assign cl_r_last_o  = last_q;

  // Pointer moves in whole beats and is back at zero when a group is out
  property p_ptr_aligned;
    @(posedge clk_i) disable iff (!rst_ni)
      ((ptr_q % SLICES) == 0) && (cl_r_valid_o -> (ptr_q == '0));
  endproperty
  a_ptr_aligned: assert property (p_ptr_aligned)
    else $error("cluster pointer off a beat boundary");

endmodule

//--- source/ldst_read_top.sv
`timescale 1ns/1ps
`include "ldst_params.svh"

module ldst_read_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,

  // Vector load request
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  ldst_addr_pkg::addr_t                        req_addr_i,
  input  ldst_addr_pkg::vl_t                          req_vl_i,
  input  ldst_addr_pkg::vsew_t                        req_vsew_i,

  // AR channel
  output logic                                        ar_valid_o,
  input  logic                                        ar_ready_i,
  output ldst_addr_pkg::addr_t                        ar_addr_o,
  output ldst_addr_pkg::ar_len_t                      ar_len_o,
  output logic                                        done_o,

  // R channel
  input  logic                                        r_valid_i,
  output logic                                        r_ready_o,
  input  ldst_beat_pkg::axi_data_t                    r_data_i,
  input  ldst_beat_pkg::rresp_t                       r_resp_i,
  input  logic                                        r_last_i,

  // Cluster read ports
  output logic                                        cl_r_valid_o,
  output ldst_beat_pkg::cl_data_t [`LDST_NR_CL-1:0]   cl_r_data_o,
  output ldst_beat_pkg::rresp_t                       cl_r_resp_o,
  output logic                                        cl_r_last_o,
  input  logic [`LDST_NR_CL-1:0]                      cl_r_ready_i
);

  burst_if u_burst_if ();

  ar_req_ctrl u_ar_req_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_vl_i    (req_vl_i),
    .req_vsew_i  (req_vsew_i),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_addr_o   (ar_addr_o),
    .ar_len_o    (ar_len_o),
    .done_o      (done_o),
    .burst       (u_burst_if.ctrl)
  );

  burst_calc u_burst_calc (
    .burst (u_burst_if.calc)
  );

  r_beat_distributor u_r_beat_distributor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .r_last_i     (r_last_i),
    .cl_r_ready_i (cl_r_ready_i),
    .cl_r_valid_o (cl_r_valid_o),
    .cl_r_data_o  (cl_r_data_o),
    .cl_r_resp_o  (cl_r_resp_o),
    .cl_r_last_o  (cl_r_last_o)
  );

endmodule

//--- testbench/tb_ldst_read.sv
`timescale 1ns/1ps
`include "ldst_params.svh"

module tb_ldst_read;
  import ldst_addr_pkg::*;
  import ldst_beat_pkg::*;

  localparam int     NR_CL     = `LDST_NR_CL;
  localparam int     SLICES    = `LDST_AXI_DATA_W / `LDST_CL_DATA_W;
  localparam longint BEAT      = `LDST_AXI_DATA_W / 8;
  localparam longint PAGE      = 1 << `LDST_PAGE_BITS;
  localparam longint MAXB      = `LDST_MAX_BURST;
  localparam int     NUM_TESTS = 6;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_valid_i;
  logic                   req_ready_o;
  addr_t                  req_addr_i;
  vl_t                    req_vl_i;
  vsew_t                  req_vsew_i;
  logic                   ar_valid_o;
  logic                   ar_ready_i;
  addr_t                  ar_addr_o;
  ar_len_t                ar_len_o;
  logic                   done_o;
  logic                   r_valid_i;
  logic                   r_ready_o;
  axi_data_t              r_data_i;
  rresp_t                 r_resp_i;
  logic                   r_last_i;
  logic                   cl_r_valid_o;
  cl_data_t [NR_CL-1:0]   cl_r_data_o;
  rresp_t                 cl_r_resp_o;
  logic                   cl_r_last_o;
  logic [NR_CL-1:0]       cl_r_ready_i;

  // Reference model state
  addr_t                  q_addr[$];
  ar_len_t                q_len[$];
  logic                   q_last[$];
  addr_t                  exp_addr;
  ar_len_t                exp_len;
  logic                   exp_last;
  int                     exp_pending;
  cl_data_t [NR_CL-1:0]   exp_data;
  rresp_t                 exp_resp;
  logic                   exp_rlast;
  int                     m_ptr;
  logic                   grp_close;

  logic [31:0]            rng;
  logic [31:0]            rng_ar;
  logic                   ar_stall;
  int                     err_cnt;
  int                     mark;
  int                     pass_cnt;
  int                     fail_cnt;

  ldst_read_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Splits one load into the bursts the AR channel should carry
  function automatic void split_load(input addr_t addr, input vl_t vl, input vsew_t vsew);
    longint a;
    longint v;
    longint start;
    longint last;
    longint beats;
    longint nxt;
    longint done_vl;
    logic   fin;
    a   = addr;
    v   = vl;
    fin = 1'b0;
    while (!fin) begin
      start = a - (a % BEAT);
      last  = ((a + (v << vsew) - 1) / BEAT) * BEAT + BEAT - 1;
      if (last / PAGE != start / PAGE) begin
        last = (start / PAGE) * PAGE + PAGE - 1;
      end
      beats = (last - start) / BEAT + 1;
      if (beats > MAXB) begin
        beats = MAXB;
        last  = start + MAXB * BEAT - 1;
      end
      nxt     = last + 1;
      done_vl = (nxt - a) >> vsew;
      fin     = (v <= done_vl);
      q_addr.push_back(addr_t'(a));
      q_len.push_back(ar_len_t'(beats - 1));
      q_last.push_back(fin);
      a = nxt;
      v = v - done_vl;
    end
  endfunction

  function automatic void load_head();
    exp_pending = q_addr.size();
    if (exp_pending > 0) begin
      exp_addr = q_addr[0];
      exp_len  = q_len[0];
      exp_last = q_last[0];
    end
  endfunction

  // Advance the model on every AR and R handshake
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      m_ptr = 0;
    end else begin
      if (ar_valid_o && ar_ready_i && q_addr.size() > 0) begin
        void'(q_addr.pop_front());
        void'(q_len.pop_front());
        void'(q_last.pop_front());
        load_head();
      end
      if (r_valid_i && (&cl_r_ready_i)) begin
        for (int i = 0; i < SLICES; i++) begin
          exp_data[m_ptr + i] = r_data_i[i*`LDST_CL_DATA_W +: `LDST_CL_DATA_W];
        end
        if (grp_close) begin
          exp_resp  = r_resp_i;
          exp_rlast = r_last_i;
          m_ptr     = 0;
        end else begin
          m_ptr = m_ptr + SLICES;
        end
      end
    end
  end

  assign grp_close = r_valid_i && (&cl_r_ready_i)
                     && ((m_ptr + SLICES == NR_CL) || r_last_i);

  a_ar_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && ar_ready_i |-> exp_pending > 0 && ar_addr_o == exp_addr
      && ar_len_o == exp_len && done_o == exp_last)
    else begin
      err_cnt++;
      $display("ERROR %0t: AR addr %h len %0d done %b, expected addr %h len %0d done %b",
               $time, $sampled(ar_addr_o), $sampled(ar_len_o), $sampled(done_o),
               $sampled(exp_addr), $sampled(exp_len), $sampled(exp_last));
    end

  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o))
    else begin
      err_cnt++;
      $display("ERROR %0t: AR fields changed during a stall", $time);
    end

  a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ar_valid_o |-> !req_ready_o) and (done_o |=> req_ready_o && !ar_valid_o))
    else begin
      err_cnt++;
      $display("ERROR %0t: req_ready_o wrong around done_o", $time);
    end

  // R ready needs every cluster ready
  a_r_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_ready_o == &cl_r_ready_i)
    else begin
      err_cnt++;
      $display("ERROR %0t: r_ready_o %b with cluster ready %b",
               $time, $sampled(r_ready_o), $sampled(cl_r_ready_i));
    end

  a_group: assert property (@(posedge clk_i) disable iff (!rst_ni)
    grp_close |=> cl_r_valid_o && cl_r_data_o === exp_data
      && cl_r_resp_o == exp_resp && cl_r_last_o == exp_rlast)
    else begin
      err_cnt++;
      $display("ERROR %0t: cluster group data %h resp %0d last %b, expected %h resp %0d last %b",
               $time, cl_r_data_o, cl_r_resp_o, cl_r_last_o, exp_data, exp_resp, exp_rlast);
    end

  a_no_group: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !grp_close |=> !cl_r_valid_o)
    else begin
      err_cnt++;
      $display("ERROR %0t: cl_r_valid_o without a closed group", $time);
    end

  // Stall pattern on AR ready, driven after each rising edge
  initial begin
    forever begin
      @(posedge clk_i);
      #2;
      rng_ar     = lcg(rng_ar);
      ar_ready_i = ar_stall ? (rng_ar[31:30] != 2'b00) : 1'b1;
    end
  end

  task automatic issue_load(input addr_t addr, input vl_t vl, input vsew_t vsew);
    split_load(addr, vl, vsew);
    load_head();
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_vl_i    = vl;
    req_vsew_i  = vsew;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    do @(negedge clk_i); while (!done_o);
    @(posedge clk_i);
    #2;
    a_all_bursts: assert (q_addr.size() == 0)
      else begin
        err_cnt++;
        $display("ERROR %0t: %0d expected bursts never issued", $time, q_addr.size());
      end
  endtask

  task automatic send_beats(input int n);
    logic             hs;
    logic [NR_CL-1:0] mask;
    for (int b = 0; b < n; b++) begin
      rng = lcg(rng);
      r_data_i[31:0] = rng;
      rng = lcg(rng);
      r_data_i[63:32] = rng;
      r_resp_i  = rng[5:4];
      r_last_i  = (b == n - 1);
      r_valid_i = 1'b1;
      do begin
        rng  = lcg(rng);
        mask = '1;
        // One cluster stalls on about a quarter of the cycles
        if (rng[31:30] == 2'b00) mask[rng[18:16]] = 1'b0;
        cl_r_ready_i = mask;
        @(posedge clk_i);
        hs = r_ready_o;
        #2;
      end while (!hs);
    end
    r_valid_i    = 1'b0;
    r_last_i     = 1'b0;
    cl_r_ready_i = '1;
  endtask

  task automatic report_test(input string name);
    if (err_cnt == mark) begin
      pass_cnt++;
      $display("Test %s: PASS", name);
    end else begin
      fail_cnt++;
      $display("Test %s: FAIL (%0d errors)", name, err_cnt - mark);
    end
    mark = err_cnt;
  endtask

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk_i);
    $display("Watchdog expired: the run did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rng          = 32'h248;
    rng_ar       = 32'h248;
    ar_stall     = 1'b0;
    err_cnt      = 0;
    mark         = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_vl_i     = '0;
    req_vsew_i   = '0;
    ar_ready_i   = 1'b1;
    r_valid_i    = 1'b0;
    r_data_i     = '0;
    r_resp_i     = '0;
    r_last_i     = 1'b0;
    cl_r_ready_i = '1;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;
    a_reset_state: assert (!ar_valid_o && !done_o && !cl_r_valid_o && req_ready_o)
      else begin
        err_cnt++;
        $display("ERROR %0t: outputs not idle after reset", $time);
      end

    issue_load(32'h0000_1000, 16'd10, 2'd1);
    report_test("aligned short load");
    issue_load(32'h0000_2003, 16'd600, 2'd2);
    report_test("unaligned start");
    issue_load(32'h0000_3f80, 16'd64, 2'd3);
    report_test("page crossing");
    issue_load(32'h0000_5000, 16'd1024, 2'd2);
    report_test("burst limit");

    ar_stall = 1'b1;
    repeat (6) begin
      rng = lcg(rng);
      issue_load(32'h0001_0000 | addr_t'(rng[31:16]), vl_t'(1 + rng[15:0] % 2000), rng[9:8]);
    end
    report_test("random AR stalls");
    ar_stall = 1'b0;

    repeat (5) begin
      rng = lcg(rng);
      send_beats(1 + rng[31:29]);
    end
    repeat (2) @(posedge clk_i);
    #2;
    report_test("read distribution");

    $display("Summary: pass %0d, fail %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- ldst_read.f
+incdir+source
source/ldst_addr_pkg.sv
source/ldst_beat_pkg.sv
source/burst_if.sv
source/burst_calc.sv
source/ar_req_ctrl.sv
source/r_beat_distributor.sv
source/ldst_read_top.sv
testbench/tb_ldst_read.sv

//--- Bender.yml
package:
  name: ldst_read

export_include_dirs:
  - source

sources:
  - source/ldst_addr_pkg.sv
  - source/ldst_beat_pkg.sv
  - source/burst_if.sv
  - source/burst_calc.sv
  - source/ar_req_ctrl.sv
  - source/r_beat_distributor.sv
  - source/ldst_read_top.sv
  - target: test
    files:
      - testbench/tb_ldst_read.sv
